/* ttc_defines.svh */
// widths, offsets and reset values for one timer channel; offsets are byte addresses on an 8-bit bus
`ifndef TTC_DEFINES_SVH
`define TTC_DEFINES_SVH

// --------------------
// bus and field widths
// --------------------
`define TTC_ADDR_W        8
`define TTC_DATA_W        32
`define TTC_CNT_W         16
`define TTC_CLK_CTRL_W    7
`define TTC_CNTR_CTRL_W   5
`define TTC_EVT_W         3

// --------------------
// register offsets
// --------------------
`define TTC_ADDR_CLK_CTRL   8'h00
`define TTC_ADDR_CNTR_CTRL  8'h04
// read only
`define TTC_ADDR_COUNT      8'h08
`define TTC_ADDR_INTERVAL   8'h0C
`define TTC_ADDR_MATCH      8'h10
// read only, cleared by the read
`define TTC_ADDR_INT_STAT   8'h14
`define TTC_ADDR_INT_EN     8'h18

// --------------------
// reset values
// --------------------
`define TTC_CLK_CTRL_RST    7'h00
// counter comes out of reset disabled
`define TTC_CNTR_CTRL_RST   5'b00001
`define TTC_INT_EN_RST      3'b000

`endif

/* ttc_reg_pkg.sv */
// register-side types; field layouts assume the widths in ttc_defines.svh and bit 0 as lsb
`include "ttc_defines.svh"

package ttc_reg_pkg;

  // --------------------
  // bus vectors
  // --------------------
  typedef logic [`TTC_ADDR_W-1:0] apb_addr_t;
  typedef logic [`TTC_DATA_W-1:0] apb_data_t;

  // clock control, msb first
  // divide ratio is 2**(prescale_val+1) when prescale_en is set
  typedef struct packed {
    // external clock select, stored only
    logic [1:0] ext_sel;
    logic [3:0] prescale_val;
    logic       prescale_en;
  } clk_ctrl_t;

  // counter control, msb first
  typedef struct packed {
    // self clearing, reads back as 0
    logic restart;
    logic match_en;
    logic decrement;
    logic interval_mode;
    logic cnt_disable;
  } cntr_ctrl_t;

  // per-register strobes out of the decoder
  typedef struct packed {
    logic clk_ctrl_sel;
    logic cntr_ctrl_sel;
    logic interval_sel;
    logic match_sel;
    logic int_en_sel;
    // read of the status register in its access cycle
    logic int_stat_rd;
  } ttc_reg_sel_t;

endpackage

/* ttc_count_pkg.sv */
// count-side types; events are single-cycle pulses, bit order interval, match, overflow from lsb
`include "ttc_defines.svh"

package ttc_count_pkg;

  // --------------------
  // count path vectors
  // --------------------
  typedef logic [`TTC_CNT_W-1:0] count_t;

  // wide enough for the largest ratio 2**16
  typedef logic [15:0] prescale_cnt_t;

  // event pulses, msb first so interval sits at bit 0
  typedef struct packed {
    logic overflow;
    logic match;
    logic interval;
  } ttc_event_t;

  // restart edge tracking
  typedef enum logic {
    RST_IDLE,
    RST_HELD
  } restart_state_t;

endpackage

/* ttc_reg_if_lite.sv */
// APB register decode; no wait states or errors, unmapped offsets read 0 and ignore writes
`timescale 1ns/100ps
`include "ttc_defines.svh"

module ttc_reg_if_lite (
  input  logic                      pclk14,
  input  logic                      n_p_reset14,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  ttc_reg_pkg::apb_addr_t    paddr,
  input  ttc_reg_pkg::clk_ctrl_t    clk_ctrl,
  input  ttc_reg_pkg::cntr_ctrl_t   cntr_ctrl,
  input  ttc_count_pkg::count_t     count_value,
  input  ttc_count_pkg::count_t     interval,
  input  ttc_count_pkg::count_t     match_value,
  input  logic [`TTC_EVT_W-1:0]     int_stat,
  input  logic [`TTC_EVT_W-1:0]     int_en,
  output ttc_reg_pkg::ttc_reg_sel_t reg_sel,
  output ttc_reg_pkg::apb_data_t    prdata
);

  import ttc_reg_pkg::*;

  // access phase of a write or a read
  logic       wr_access;
  logic       rd_access;
  // counter control with restart masked for readback
  cntr_ctrl_t cntr_ctrl_rd;
  apb_data_t  rd_mux;

  assign wr_access = psel & penable & pwrite;
  assign rd_access = psel & penable & ~pwrite;

  // --------------------
  // write strobes
  // --------------------
  assign reg_sel.clk_ctrl_sel  = wr_access & (paddr == `TTC_ADDR_CLK_CTRL);
  assign reg_sel.cntr_ctrl_sel = wr_access & (paddr == `TTC_ADDR_CNTR_CTRL);
  assign reg_sel.interval_sel  = wr_access & (paddr == `TTC_ADDR_INTERVAL);
  assign reg_sel.match_sel     = wr_access & (paddr == `TTC_ADDR_MATCH);
  assign reg_sel.int_en_sel    = wr_access & (paddr == `TTC_ADDR_INT_EN);
  // status clears at the end of this access
  assign reg_sel.int_stat_rd   = rd_access & (paddr == `TTC_ADDR_INT_STAT);

  // --------------------
  // read mux
  // --------------------
  always_comb
  begin
    cntr_ctrl_rd         = cntr_ctrl;
    cntr_ctrl_rd.restart = 1'b0;
    rd_mux               = '0;
    case (paddr)
      `TTC_ADDR_CLK_CTRL:  rd_mux[`TTC_CLK_CTRL_W-1:0]  = clk_ctrl;
      `TTC_ADDR_CNTR_CTRL: rd_mux[`TTC_CNTR_CTRL_W-1:0] = cntr_ctrl_rd;
      `TTC_ADDR_COUNT:     rd_mux[`TTC_CNT_W-1:0]       = count_value;
      `TTC_ADDR_INTERVAL:  rd_mux[`TTC_CNT_W-1:0]       = interval;
      `TTC_ADDR_MATCH:     rd_mux[`TTC_CNT_W-1:0]       = match_value;
      `TTC_ADDR_INT_STAT:  rd_mux[`TTC_EVT_W-1:0]       = int_stat;
      `TTC_ADDR_INT_EN:    rd_mux[`TTC_EVT_W-1:0]       = int_en;
      default:             rd_mux                       = '0;
    endcase
  end

  // bus reads 0 when not selected
  assign prdata = psel ? rd_mux : '0;

  // only one register may take a write per access
  a_one_write_sel : assert property (
    @(posedge pclk14) disable iff (!n_p_reset14)
    $onehot0({reg_sel.clk_ctrl_sel, reg_sel.cntr_ctrl_sel, reg_sel.interval_sel,
              reg_sel.match_sel, reg_sel.int_en_sel})
  );

endmodule

/* ttc_count_rst_lite.sv */
// clock control register and restart handling; bits 6..5 are stored but have no effect
`timescale 1ns/100ps
`include "ttc_defines.svh"

module ttc_count_rst_lite (
  input  logic                    pclk14,
  input  logic                    n_p_reset14,
  input  logic                    clk_ctrl_sel,
  input  logic                    restart,
  input  ttc_reg_pkg::clk_ctrl_t  pwdata,
  output logic                    count_en,
  output ttc_reg_pkg::clk_ctrl_t  clk_ctrl
);

  import ttc_count_pkg::*;

  restart_state_t rst_state;

  // --------------------
  // count enable
  // --------------------
  // one low cycle per rising restart, held off while restart stays high
  always_ff @(posedge pclk14 or negedge n_p_reset14)
  begin
    if (!n_p_reset14)
    begin
      rst_state <= RST_IDLE;
      count_en  <= 1'b0;
    end
    else
    begin
      case (rst_state)
        RST_IDLE:
        begin
          if (restart)
          begin
            rst_state <= RST_HELD;
            count_en  <= 1'b0;
          end
          else
          begin
            count_en <= 1'b1;
          end
        end
        RST_HELD:
        begin
          count_en <= 1'b1;
          // rearm once restart drops
          if (!restart)
          begin
            rst_state <= RST_IDLE;
          end
        end
        default:
        begin
          rst_state <= RST_IDLE;
          count_en  <= 1'b1;
        end
      endcase
    end
  end

  // --------------------
  // clock control register
  // --------------------
  always_ff @(posedge pclk14 or negedge n_p_reset14)
  begin
    if (!n_p_reset14)
    begin
      clk_ctrl <= `TTC_CLK_CTRL_RST;
    end
    else if (clk_ctrl_sel)
    begin
      clk_ctrl <= pwdata;
    end
  end

  // restart drop never lasts past one cycle
  a_count_en_drop : assert property (
    @(posedge pclk14) disable iff (!n_p_reset14)
    !count_en |=> count_en
  );

endmodule

/* ttc_clock_prescaler_lite.sv */
// power-of-two prescaler; period restarts from the first cycle with count_en high
`timescale 1ns/100ps

module ttc_clock_prescaler_lite (
  input  logic                    pclk14,
  input  logic                    n_p_reset14,
  input  logic                    count_en,
  input  ttc_reg_pkg::clk_ctrl_t  clk_ctrl,
  output logic                    tick
);

  import ttc_count_pkg::*;

  prescale_cnt_t ps_cnt;
  // last count value of a period, 2**(N+1)-1
  prescale_cnt_t ps_terminal;
  logic          ps_wrap;

  // shifting out all ones for N=15 leaves 0xFFFF
  assign ps_terminal = ~(prescale_cnt_t'('1) << ({1'b0, clk_ctrl.prescale_val} + 5'd1));
  assign ps_wrap     = (ps_cnt == ps_terminal);

  // --------------------
  // prescale counter
  // --------------------
  always_ff @(posedge pclk14 or negedge n_p_reset14)
  begin
    if (!n_p_reset14)
    begin
      ps_cnt <= '0;
    end
    else if (!count_en || ps_wrap)
    begin
      ps_cnt <= '0;
    end
    else
    begin
      ps_cnt <= ps_cnt + 1'b1;
    end
  end

  // every count_en cycle when undivided
  assign tick = count_en & (~clk_ctrl.prescale_en | ps_wrap);

  // no tick during the restart drop
  a_no_tick_when_off : assert property (
    @(posedge pclk14) disable iff (!n_p_reset14)
    tick |-> count_en
  );

endmodule

/* ttc_counter_lite.sv */
// 16-bit up/down counter; reprogramming interval below the count in up mode runs to 0xFFFF first
`timescale 1ns/100ps
`include "ttc_defines.svh"

module ttc_counter_lite (
  input  logic                      pclk14,
  input  logic                      n_p_reset14,
  input  logic                      tick,
  input  logic                      count_en,
  input  ttc_reg_pkg::ttc_reg_sel_t reg_sel,
  input  ttc_reg_pkg::apb_data_t    pwdata,
  output logic                      restart,
  output ttc_reg_pkg::cntr_ctrl_t   cntr_ctrl,
  output ttc_count_pkg::count_t     count_value,
  output ttc_count_pkg::count_t     interval,
  output ttc_count_pkg::count_t     match_value,
  output ttc_count_pkg::ttc_event_t events
);

  import ttc_reg_pkg::*;
  import ttc_count_pkg::*;

  // value loaded on restart and on interval reload
  count_t start_value;
  // count at its wrap or reload point
  logic   at_limit;
  logic   step_en;
  // count took a new value at the last edge
  logic   count_upd;

  // --------------------
  // control registers
  // --------------------
  always_ff @(posedge pclk14 or negedge n_p_reset14)
  begin
    if (!n_p_reset14)
    begin
      cntr_ctrl <= `TTC_CNTR_CTRL_RST;
    end
    else if (reg_sel.cntr_ctrl_sel)
    begin
      cntr_ctrl <= cntr_ctrl_t'(pwdata[`TTC_CNTR_CTRL_W-1:0]);
    end
    else
    begin
      // restart lasts one cycle
      cntr_ctrl.restart <= 1'b0;
    end
  end

  always_ff @(posedge pclk14 or negedge n_p_reset14)
  begin
    if (!n_p_reset14)
    begin
      interval    <= '0;
      match_value <= '0;
    end
    else
    begin
      if (reg_sel.interval_sel)
      begin
        interval <= pwdata[`TTC_CNT_W-1:0];
      end
      if (reg_sel.match_sel)
      begin
        match_value <= pwdata[`TTC_CNT_W-1:0];
      end
    end
  end

  assign restart = cntr_ctrl.restart;

  // --------------------
  // count path
  // --------------------
  always_comb
  begin
    start_value = '0;
    if (cntr_ctrl.decrement)
    begin
      start_value = cntr_ctrl.interval_mode ? interval : count_t'('1);
    end
    // down stops at 0, up at interval or all ones
    if (cntr_ctrl.decrement)
    begin
      at_limit = (count_value == '0);
    end
    else if (cntr_ctrl.interval_mode)
    begin
      at_limit = (count_value == interval);
    end
    else
    begin
      at_limit = (count_value == count_t'('1));
    end
  end

  assign step_en = count_en & tick & ~cntr_ctrl.cnt_disable;

  always_ff @(posedge pclk14 or negedge n_p_reset14)
  begin
    if (!n_p_reset14)
    begin
      count_value <= '0;
      count_upd   <= 1'b0;
    end
    else
    begin
      count_upd <= ~count_en | step_en;
      if (!count_en)
      begin
        count_value <= start_value;
      end
      else if (step_en)
      begin
        if (cntr_ctrl.interval_mode && at_limit)
        begin
          count_value <= start_value;
        end
        // overflow mode wraps through the natural carry
        else if (cntr_ctrl.decrement)
        begin
          count_value <= count_value - 1'b1;
        end
        else
        begin
          count_value <= count_value + 1'b1;
        end
      end
    end
  end

  // --------------------
  // event pulses
  // --------------------
  always_ff @(posedge pclk14 or negedge n_p_reset14)
  begin
    if (!n_p_reset14)
    begin
      events <= '0;
    end
    else
    begin
      events.interval <= step_en & cntr_ctrl.interval_mode & at_limit;
      events.overflow <= step_en & ~cntr_ctrl.interval_mode & at_limit;
      // once per arrival at the match value
      events.match    <= cntr_ctrl.match_en & count_upd & (count_value == match_value);
    end
  end

endmodule

/* ttc_interrupt_lite.sv */
// sticky event status cleared by reading it; an event in the read cycle stays set
`timescale 1ns/100ps
`include "ttc_defines.svh"

module ttc_interrupt_lite (
  input  logic                      pclk14,
  input  logic                      n_p_reset14,
  input  ttc_count_pkg::ttc_event_t events,
  input  ttc_reg_pkg::ttc_reg_sel_t reg_sel,
  input  ttc_reg_pkg::apb_data_t    pwdata,
  output logic [`TTC_EVT_W-1:0]     int_stat,
  output logic [`TTC_EVT_W-1:0]     int_en,
  output logic                      irq
);

  // --------------------
  // status and enable
  // --------------------
  always_ff @(posedge pclk14 or negedge n_p_reset14)
  begin
    if (!n_p_reset14)
    begin
      int_stat <= '0;
      int_en   <= `TTC_INT_EN_RST;
    end
    else
    begin
      // new events win over the read clear
      int_stat <= (reg_sel.int_stat_rd ? '0 : int_stat) | events;
      if (reg_sel.int_en_sel)
      begin
        int_en <= pwdata[`TTC_EVT_W-1:0];
      end
    end
  end

  // registered interrupt line
  always_ff @(posedge pclk14 or negedge n_p_reset14)
  begin
    if (!n_p_reset14)
    begin
      irq <= 1'b0;
    end
    else
    begin
      irq <= |(int_stat & int_en);
    end
  end

  // irq always traces back to an enabled status bit
  a_irq_source : assert property (
    @(posedge pclk14) disable iff (!n_p_reset14)
    irq |-> $past(|(int_stat & int_en))
  );

endmodule

/* ttc_timer_counter_lite.sv */
// single timer channel top; internal clock only, every APB access takes two cycles
`timescale 1ns/100ps
`include "ttc_defines.svh"

module ttc_timer_counter_lite (
  input  logic                   pclk14,
  input  logic                   n_p_reset14,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  ttc_reg_pkg::apb_addr_t paddr,
  input  ttc_reg_pkg::apb_data_t pwdata,
  output ttc_reg_pkg::apb_data_t prdata,
  output logic                   irq
);

  import ttc_reg_pkg::*;
  import ttc_count_pkg::*;

  // --------------------
  // internal wires
  // --------------------
  ttc_reg_sel_t          reg_sel;
  clk_ctrl_t             clk_ctrl;
  cntr_ctrl_t            cntr_ctrl;
  count_t                count_value;
  count_t                interval;
  count_t                match_value;
  ttc_event_t            events;
  logic [`TTC_EVT_W-1:0] int_stat;
  logic [`TTC_EVT_W-1:0] int_en;
  logic                  restart;
  logic                  count_en;
  logic                  tick;

  // bus decode and readback
  ttc_reg_if_lite i_reg_if (
    .pclk14      (pclk14),
    .n_p_reset14 (n_p_reset14),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .clk_ctrl    (clk_ctrl),
    .cntr_ctrl   (cntr_ctrl),
    .count_value (count_value),
    .interval    (interval),
    .match_value (match_value),
    .int_stat    (int_stat),
    .int_en      (int_en),
    .reg_sel     (reg_sel),
    .prdata      (prdata)
  );

  // clock control and restart
  ttc_count_rst_lite i_count_rst (
    .pclk14       (pclk14),
    .n_p_reset14  (n_p_reset14),
    .clk_ctrl_sel (reg_sel.clk_ctrl_sel),
    .restart      (restart),
    .pwdata       (clk_ctrl_t'(pwdata[`TTC_CLK_CTRL_W-1:0])),
    .count_en     (count_en),
    .clk_ctrl     (clk_ctrl)
  );

  // tick source
  ttc_clock_prescaler_lite i_prescaler (
    .pclk14      (pclk14),
    .n_p_reset14 (n_p_reset14),
    .count_en    (count_en),
    .clk_ctrl    (clk_ctrl),
    .tick        (tick)
  );

  // tick consumer
  ttc_counter_lite i_counter (
    .pclk14      (pclk14),
    .n_p_reset14 (n_p_reset14),
    .tick        (tick),
    .count_en    (count_en),
    .reg_sel     (reg_sel),
    .pwdata      (pwdata),
    .restart     (restart),
    .cntr_ctrl   (cntr_ctrl),
    .count_value (count_value),
    .interval    (interval),
    .match_value (match_value),
    .events      (events)
  );

  // event buffer until software reads it
  ttc_interrupt_lite i_interrupt (
    .pclk14      (pclk14),
    .n_p_reset14 (n_p_reset14),
    .events      (events),
    .reg_sel     (reg_sel),
    .pwdata      (pwdata),
    .int_stat    (int_stat),
    .int_en      (int_en),
    .irq         (irq)
  );

endmodule

/* tb_ttc_timer_counter_lite.sv */
// testbench for one timer channel; a cycle model tracks the DUT and every bus read and irq is compared
`timescale 1ns/100ps
`include "ttc_defines.svh"

module tb_ttc_timer_counter_lite;

  // --------------------
  // run length in cycles
  // --------------------
  localparam int RESET_CYCLES    = 8;
  localparam int REG_CYCLES      = 100;
  localparam int RESTART_CYCLES  = 40;
  localparam int PRESCALE_CYCLES = 3 * 50;
  localparam int INTERVAL_CYCLES = 2 * 100;
  localparam int MATCH_CYCLES    = 200;
  // down count from 0xffff to 0
  localparam int OVERFLOW_CYCLES = 68000;
  localparam int MAX_CYCLES      = RESET_CYCLES + REG_CYCLES + RESTART_CYCLES + PRESCALE_CYCLES
                                   + INTERVAL_CYCLES + MATCH_CYCLES + OVERFLOW_CYCLES + 500;

  // cycle model state, events as {overflow, match, interval}
  typedef struct packed {
    logic [6:0]  clk_ctrl;
    logic [4:0]  cntr_ctrl;
    logic [15:0] interval;
    logic [15:0] match;
    logic [2:0]  int_en;
    logic [2:0]  int_stat;
    logic        irq;
    logic        held;
    logic        count_en;
    logic [15:0] ps_cnt;
    logic [15:0] count;
    logic        took;
    logic [2:0]  events;
  } model_t;

  logic        pclk14;
  logic        n_p_reset14;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        irq;

  model_t      model;
  integer      seed;
  string       test_name;
  int          cycle_count = 0;

  ttc_timer_counter_lite i_dut (
    .pclk14      (pclk14),
    .n_p_reset14 (n_p_reset14),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .irq         (irq)
  );

  initial
  begin
    pclk14 = 1'b0;
    forever #10 pclk14 = ~pclk14;
  end

  // --------------------
  // reference model
  // --------------------
  function automatic model_t reset_model();
    model_t r;
    r           = '0;
    r.clk_ctrl  = `TTC_CLK_CTRL_RST;
    r.cntr_ctrl = `TTC_CNTR_CTRL_RST;
    r.int_en    = `TTC_INT_EN_RST;
    return r;
  endfunction

  // one clock edge of the channel, from the bus inputs seen before the edge
  function automatic model_t next_state(input model_t s, input logic sel, input logic en,
                                        input logic wr, input logic [7:0] addr,
                                        input logic [31:0] wdata);
    model_t      n;
    logic        wr_acc;
    logic        stat_rd;
    logic        tick;
    logic        step;
    logic        at_end;
    logic        down;
    logic        ival;
    logic        restart;
    logic [15:0] period_end;
    logic [15:0] start;
    n          = s;
    wr_acc     = sel & en & wr;
    stat_rd    = sel & en & ~wr & (addr == `TTC_ADDR_INT_STAT);
    down       = s.cntr_ctrl[2];
    ival       = s.cntr_ctrl[1];
    restart    = s.cntr_ctrl[4];
    // last cycle of a 2**(N+1) period
    period_end = (16'd2 << s.clk_ctrl[4:1]) - 16'd1;
    tick       = s.count_en & (~s.clk_ctrl[0] | (s.ps_cnt == period_end));
    step       = tick & ~s.cntr_ctrl[0];
    start      = down ? (ival ? s.interval : 16'hFFFF) : 16'h0000;
    if (down)
      at_end = (s.count == 16'h0000);
    else
      at_end = ival ? (s.count == s.interval) : (s.count == 16'hFFFF);
    // restart drops count_en once per rising level
    n.count_en = ~(restart & ~s.held);
    n.held     = restart;
    n.ps_cnt   = (!s.count_en || s.ps_cnt == period_end) ? 16'd0 : s.ps_cnt + 16'd1;
    // count path
    n.took = ~s.count_en | step;
    if (!s.count_en)
      n.count = start;
    else if (step && ival && at_end)
      n.count = start;
    else if (step)
      n.count = down ? s.count - 16'd1 : s.count + 16'd1;
    n.events[0] = step & ival & at_end;
    n.events[1] = s.cntr_ctrl[3] & s.took & (s.count == s.match);
    n.events[2] = step & ~ival & at_end;
    // sticky status, new events beat the read clear
    n.int_stat = (stat_rd ? 3'b000 : s.int_stat) | s.events;
    n.irq      = |(s.int_stat & s.int_en);
    // register writes
    n.cntr_ctrl[4] = 1'b0;
    if (wr_acc)
    begin
      case (addr)
        `TTC_ADDR_CLK_CTRL:  n.clk_ctrl  = wdata[6:0];
        `TTC_ADDR_CNTR_CTRL: n.cntr_ctrl = wdata[4:0];
        `TTC_ADDR_INTERVAL:  n.interval  = wdata[15:0];
        `TTC_ADDR_MATCH:     n.match     = wdata[15:0];
        `TTC_ADDR_INT_EN:    n.int_en    = wdata[2:0];
        default:             n.int_en    = s.int_en;
      endcase
    end
    return n;
  endfunction

  // bus view of the model, restart reads 0
  function automatic logic [31:0] read_value(input model_t s, input logic [7:0] addr);
    case (addr)
      `TTC_ADDR_CLK_CTRL:  return {25'b0, s.clk_ctrl};
      `TTC_ADDR_CNTR_CTRL: return {28'b0, s.cntr_ctrl[3:0]};
      `TTC_ADDR_COUNT:     return {16'b0, s.count};
      `TTC_ADDR_INTERVAL:  return {16'b0, s.interval};
      `TTC_ADDR_MATCH:     return {16'b0, s.match};
      `TTC_ADDR_INT_STAT:  return {29'b0, s.int_stat};
      `TTC_ADDR_INT_EN:    return {29'b0, s.int_en};
      default:             return 32'h0;
    endcase
  endfunction

  always @(posedge pclk14 or negedge n_p_reset14)
  begin
    if (!n_p_reset14)
    begin
      model <= reset_model();
    end
    else
    begin
      model <= next_state(model, psel, penable, pwrite, paddr, pwdata);
    end
  end

  // --------------------
  // checking
  // --------------------
  task automatic compare_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("Error [%s] %s: expected %h, actual %h", test_name, what, expected, actual);
      $display("Checks failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // mid-cycle, all outputs settled
  always @(negedge pclk14)
  begin
    if (n_p_reset14)
    begin
      compare_value("irq", model.irq, irq);
      if (psel)
        compare_value("prdata", read_value(model, paddr), prdata);
    end
  end

  always @(posedge pclk14)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("Checks failed");
      $fatal(1, "timeout, tests still running after %0d cycles", cycle_count);
    end
  end

  // --------------------
  // bus tasks
  // --------------------
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge pclk14);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge pclk14);
    penable <= 1'b1;
    @(posedge pclk14);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge pclk14);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge pclk14);
    penable <= 1'b1;
    // access phase
    @(negedge pclk14);
    data = prdata;
    @(posedge pclk14);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_readback(input logic [7:0] addr, input logic [31:0] wdata,
                                input logic [31:0] expected);
    logic [31:0] data;
    apb_write(addr, wdata);
    apb_read(addr, data);
    compare_value("readback", expected, data);
  endtask

  // read status until a bit in mask shows up
  task automatic poll_status(input logic [2:0] mask, input int max_reads,
                             output logic [31:0] stat);
    int reads;
    reads = 0;
    stat  = '0;
    while ((stat[2:0] & mask) == 3'b000)
    begin
      if (reads == max_reads)
      begin
        $display("Checks failed");
        $fatal(1, "status bits %b never set within %0d reads in %s", mask, reads, test_name);
      end
      apb_read(`TTC_ADDR_INT_STAT, stat);
      reads++;
    end
  endtask

  task automatic wait_irq(input logic level, input int max_cycles);
    int cycles;
    cycles = 0;
    @(negedge pclk14);
    while (irq !== level)
    begin
      if (cycles == max_cycles)
      begin
        $display("Checks failed");
        $fatal(1, "irq did not reach %b within %0d cycles in %s", level, cycles, test_name);
      end
      @(negedge pclk14);
      cycles++;
    end
  endtask

  // --------------------
  // tests
  // --------------------
  task automatic reset_and_readback();
    logic [31:0] data;
    test_name = "reset_values";
    apb_read(`TTC_ADDR_CLK_CTRL, data);
    compare_value("clk_ctrl", `TTC_CLK_CTRL_RST, data);
    apb_read(`TTC_ADDR_CNTR_CTRL, data);
    compare_value("cntr_ctrl", `TTC_CNTR_CTRL_RST, data);
    apb_read(`TTC_ADDR_COUNT, data);
    compare_value("count", 32'h0, data);
    apb_read(`TTC_ADDR_INTERVAL, data);
    compare_value("interval", 32'h0, data);
    apb_read(`TTC_ADDR_MATCH, data);
    compare_value("match", 32'h0, data);
    apb_read(`TTC_ADDR_INT_STAT, data);
    compare_value("int_stat", 32'h0, data);
    apb_read(`TTC_ADDR_INT_EN, data);
    compare_value("int_en", `TTC_INT_EN_RST, data);
    @(negedge pclk14);
    compare_value("irq", 32'h0, irq);
    // upper bits dropped, restart reads 0
    test_name = "readback";
    write_readback(`TTC_ADDR_CLK_CTRL, 32'hFFFF_FFDB, 32'h5B);
    write_readback(`TTC_ADDR_CNTR_CTRL, 32'hFFFF_FFF7, 32'h07);
    write_readback(`TTC_ADDR_INTERVAL, 32'hFFFF_A5C3, 32'hA5C3);
    write_readback(`TTC_ADDR_MATCH, 32'h0000_3C5A, 32'h3C5A);
    write_readback(`TTC_ADDR_INT_EN, 32'h0000_0005, 32'h5);
    apb_write(`TTC_ADDR_INT_EN, 32'h0);
  endtask

  // count reloads 0 two edges after the write, then steps each cycle
  task automatic restart_count();
    logic [31:0] data;
    test_name = "restart";
    apb_write(`TTC_ADDR_CLK_CTRL, 32'h0);
    // up, overflow mode, enabled, restart
    apb_write(`TTC_ADDR_CNTR_CTRL, 32'h10);
    for (int i = 0; i < 6; i++)
    begin
      apb_read(`TTC_ADDR_COUNT, data);
      compare_value("count after restart", 3 * i, data);
    end
  endtask

  task automatic prescale_sweep();
    logic [31:0] data;
    logic [3:0]  n;
    test_name = "prescale";
    repeat (3)
    begin
      n = 4'($random(seed) & 3);
      apb_write(`TTC_ADDR_CLK_CTRL, {27'b0, n, 1'b1});
      apb_write(`TTC_ADDR_CNTR_CTRL, 32'h10);
      repeat (12) apb_read(`TTC_ADDR_COUNT, data);
    end
  endtask

  task automatic interval_wrap(input logic down);
    logic [31:0] data;
    logic [31:0] ival;
    logic [4:0]  mode;
    ival      = 32'd8 + ($random(seed) & 32'hF);
    // interval mode with restart, decrement if down
    mode      = down ? 5'b10110 : 5'b10010;
    test_name = down ? "interval_down" : "interval_up";
    apb_write(`TTC_ADDR_CLK_CTRL, 32'h0);
    apb_write(`TTC_ADDR_INTERVAL, ival);
    apb_read(`TTC_ADDR_INT_STAT, data);
    apb_write(`TTC_ADDR_CNTR_CTRL, {27'b0, mode});
    poll_status(3'b001, 20, data);
    // only the interval bit can set in interval mode without match
    compare_value("interval status set", 32'h1, data);
    // counts after the reload
    repeat (4) apb_read(`TTC_ADDR_COUNT, data);
    // stopped, same mode
    apb_write(`TTC_ADDR_CNTR_CTRL, {27'b0, (mode & 5'b01111) | 5'b00001});
    apb_read(`TTC_ADDR_INT_STAT, data);
    apb_read(`TTC_ADDR_INT_STAT, data);
    compare_value("interval status cleared", 32'h0, data);
  endtask

  task automatic match_interrupt();
    logic [31:0] data;
    logic [31:0] mval;
    mval      = 32'd4 + ($random(seed) & 32'hF);
    test_name = "match_irq";
    apb_write(`TTC_ADDR_MATCH, mval);
    apb_write(`TTC_ADDR_INT_EN, 32'h2);
    apb_read(`TTC_ADDR_INT_STAT, data);
    // up, overflow mode, match enabled, restart
    apb_write(`TTC_ADDR_CNTR_CTRL, 32'h18);
    wait_irq(1'b1, 60);
    apb_read(`TTC_ADDR_INT_STAT, data);
    compare_value("match status set", 32'h1, data[1]);
    wait_irq(1'b0, 4);
    // masked, status still sets
    test_name = "match_masked";
    apb_write(`TTC_ADDR_INT_EN, 32'h0);
    apb_write(`TTC_ADDR_CNTR_CTRL, 32'h18);
    poll_status(3'b010, 20, data);
    // no wrap this early, so match is the only bit
    compare_value("match status set", 32'h2, data);
    @(negedge pclk14);
    compare_value("irq masked", 32'h0, irq);
  endtask

  task automatic down_overflow();
    logic [31:0] data;
    test_name = "overflow";
    apb_write(`TTC_ADDR_INT_EN, 32'h4);
    apb_read(`TTC_ADDR_INT_STAT, data);
    // down, overflow mode, restart from 0xffff
    apb_write(`TTC_ADDR_CNTR_CTRL, 32'h14);
    apb_read(`TTC_ADDR_COUNT, data);
    poll_status(3'b100, 22500, data);
    // match disabled and no interval mode
    compare_value("overflow status set", 32'h4, data);
    apb_read(`TTC_ADDR_COUNT, data);
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial
  begin
    seed        = 19;
    test_name   = "reset";
    n_p_reset14 = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    repeat (RESET_CYCLES) @(posedge pclk14);
    n_p_reset14 <= 1'b1;
    reset_and_readback();
    restart_count();
    prescale_sweep();
    interval_wrap(1'b0);
    interval_wrap(1'b1);
    match_interrupt();
    down_overflow();
    $display("All checks passed");
    $finish;
  end

endmodule

/* project.f */
+incdir+.
ttc_reg_pkg.sv
ttc_count_pkg.sv
ttc_reg_if_lite.sv
ttc_count_rst_lite.sv
ttc_clock_prescaler_lite.sv
ttc_counter_lite.sv
ttc_interrupt_lite.sv
ttc_timer_counter_lite.sv
tb_ttc_timer_counter_lite.sv

/* Bender.yml */
package:
  name: ttc_timer_counter_lite

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - ttc_reg_pkg.sv
      - ttc_count_pkg.sv
      - ttc_reg_if_lite.sv
      - ttc_count_rst_lite.sv
      - ttc_clock_prescaler_lite.sv
      - ttc_counter_lite.sv
      - ttc_interrupt_lite.sv
      - ttc_timer_counter_lite.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ttc_timer_counter_lite.sv
